//--- logic/ex_alu.sv
// Integer ALU with adder, logic, shifter, set-less-than and branch compare
`timescale 1ns/1ps

module ex_alu #(
  parameter int XLEN = 32
) (
  input  logic                 clk,
  input  logic                 rst_n,

  // Operation and operands
  input  ex_op_pkg::ex_op_e    op_i,
  input  logic [XLEN-1:0]      operand_a_i,
  input  logic [XLEN-1:0]      operand_b_i,

  // Results
  output logic [XLEN-1:0]      result_o,
  output logic                 cmp_result_o,

  // Handshake
  input  logic                 valid_i,
  output logic                 valid_o,
  output logic                 ready_o,
  input  logic                 ready_i
);

  // Shift amount width, 5 bits for RV32
  localparam int SHAMT_W = $clog2(XLEN);

  logic [SHAMT_W-1:0] shamt;
  logic [XLEN-1:0]    sum;
  logic [XLEN-1:0]    diff;
  logic               is_equal;
  logic               lt_signed;
  logic               lt_unsigned;

  //////////////////////////////////////////////////
  // Datapath
  //////////////////////////////////////////////////

  // Only the low bits of operand b are a shift amount
  assign shamt = operand_b_i[SHAMT_W-1:0];

  assign sum  = operand_a_i + operand_b_i;
  assign diff = operand_a_i - operand_b_i;

  // Comparator shared by SLT/SLTU and the branches
  assign is_equal    = (operand_a_i == operand_b_i);
  assign lt_signed   = ($signed(operand_a_i) < $signed(operand_b_i));
  assign lt_unsigned = (operand_a_i < operand_b_i);

  // Result select
  always_comb
  begin
    case (op_i)
      ex_op_pkg::ADD:  result_o = sum;
      ex_op_pkg::SUB:  result_o = diff;
      ex_op_pkg::AND:  result_o = operand_a_i & operand_b_i;
      ex_op_pkg::OR:   result_o = operand_a_i | operand_b_i;
      ex_op_pkg::XOR:  result_o = operand_a_i ^ operand_b_i;
      ex_op_pkg::SLL:  result_o = operand_a_i << shamt;
      ex_op_pkg::SRL:  result_o = operand_a_i >> shamt;
      // Arithmetic shift keeps the sign bit
      ex_op_pkg::SRA:  result_o = $signed(operand_a_i) >>> shamt;
      ex_op_pkg::SLT:  result_o = {{(XLEN-1){1'b0}}, lt_signed};
      ex_op_pkg::SLTU: result_o = {{(XLEN-1){1'b0}}, lt_unsigned};
      // Branches, MUL and DIV leave the ALU result unused
      default:         result_o = '0;
    endcase
  end

  // Branch decision
  always_comb
  begin
    case (op_i)
      ex_op_pkg::BEQ:  cmp_result_o = is_equal;
      ex_op_pkg::BNE:  cmp_result_o = !is_equal;
      ex_op_pkg::BLT:  cmp_result_o = lt_signed;
      ex_op_pkg::BGE:  cmp_result_o = !lt_signed;
      ex_op_pkg::BLTU: cmp_result_o = lt_unsigned;
      ex_op_pkg::BGEU: cmp_result_o = !lt_unsigned;
      default:         cmp_result_o = 1'b0;
    endcase
  end

  // Single cycle unit, the handshake passes straight through
  assign valid_o = valid_i;
  assign ready_o = ready_i;

endmodule

//--- logic/ex_div.sv
// Restoring unsigned divider producing one quotient bit per cycle
`timescale 1ns/1ps

module ex_div #(
  parameter int XLEN = 32
) (
  input  logic               clk,
  input  logic               rst_n,

  input  ex_op_pkg::ex_op_e  op_i,
  // Dividend and divisor
  input  logic [XLEN-1:0]    operand_a_i,
  input  logic [XLEN-1:0]    operand_b_i,

  output logic [XLEN-1:0]    result_o,

  input  logic               valid_i,
  input  logic               kill_i,
  output logic               valid_o,
  output logic               ready_o,
  input  logic               ready_i
);

  localparam int CNT_W = $clog2(XLEN);

  // FSM states
  localparam logic [1:0] S_IDLE = 2'd0;
  localparam logic [1:0] S_RUN  = 2'd1;
  localparam logic [1:0] S_DONE = 2'd2;

  logic [1:0]       state_q;
  logic [CNT_W-1:0] cnt_q;

  logic [XLEN-1:0]  rem_q;
  logic [XLEN-1:0]  quot_q;
  logic [XLEN-1:0]  divisor_q;
  logic             rem_op_q;

  // One extra bit so the trial subtract shows its borrow
  logic [XLEN:0]    shifted;
  logic [XLEN:0]    trial;

  //////////////////////////////////////////////////
  // Control
  //////////////////////////////////////////////////

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q <= S_IDLE;
      cnt_q   <= '0;
    end
    else if (kill_i)
    begin
      // Abort, whatever the state
      state_q <= S_IDLE;
    end
    else
    begin
      case (state_q)
        S_IDLE:
        begin
          if (valid_i)
          begin
            state_q <= S_RUN;
            cnt_q   <= CNT_W'(XLEN - 1);
          end
        end
        S_RUN:
        begin
          // Last quotient bit is formed on this edge
          if (cnt_q == '0)
            state_q <= S_DONE;
          else
            cnt_q <= cnt_q - 1'b1;
        end
        S_DONE:
        begin
          // Hold the result until writeback takes it
          if (ready_i)
            state_q <= S_IDLE;
        end
        default: state_q <= S_IDLE;
      endcase
    end
  end

  //////////////////////////////////////////////////
  // Datapath
  //////////////////////////////////////////////////

  // Next dividend bit enters from the top of the quotient register
  assign shifted = {rem_q, quot_q[XLEN-1]};
  assign trial   = shifted - {1'b0, divisor_q};

  // Divisor of zero never borrows
  // so the quotient fills with ones and the remainder ends as the dividend
  always_ff @(posedge clk)
  begin
    if (state_q == S_IDLE && valid_i)
    begin
      rem_q     <= '0;
      quot_q    <= operand_a_i;
      divisor_q <= operand_b_i;
      rem_op_q  <= (op_i == ex_op_pkg::REMU);
    end
    else if (state_q == S_RUN)
    begin
      // Restore on borrow, else keep the difference
      rem_q  <= trial[XLEN] ? shifted[XLEN-1:0] : trial[XLEN-1:0];
      quot_q <= {quot_q[XLEN-2:0], !trial[XLEN]};
    end
  end

  assign result_o = rem_op_q ? rem_q : quot_q;
  assign valid_o  = (state_q == S_DONE);
  // Free when finishing, or idle with nothing for us
  assign ready_o  = ready_i && ((state_q == S_DONE) || (state_q == S_IDLE && !valid_i));

endmodule

//--- logic/ex_mult.sv
// Two-stage unsigned multiplier returning the low or high word of the product
`timescale 1ns/1ps

module ex_mult #(
  parameter int XLEN = 32
) (
  input  logic               clk,
  input  logic               rst_n,

  input  ex_op_pkg::ex_op_e  op_i,
  input  logic [XLEN-1:0]    operand_a_i,
  input  logic [XLEN-1:0]    operand_b_i,

  output logic [XLEN-1:0]    result_o,

  input  logic               valid_i,
  output logic               valid_o,
  output logic               ready_o,
  input  logic               ready_i
);

  // Full double-width product and word select
  logic [2*XLEN-1:0] prod_q;
  logic              high_q;
  logic              s1_valid_q;

  // First stage occupancy
  // Freed when writeback takes the result or the operation is dropped
  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      s1_valid_q <= 1'b0;
    end
    else if (s1_valid_q)
    begin
      if (ready_i || !valid_i)
        s1_valid_q <= 1'b0;
    end
    else if (valid_i)
    begin
      s1_valid_q <= 1'b1;
    end
  end

  // Operands widen to 2*XLEN in the assignment context
  always_ff @(posedge clk)
  begin
    if (valid_i && !s1_valid_q)
    begin
      prod_q <= operand_a_i * operand_b_i;
      high_q <= (op_i == ex_op_pkg::MULHU);
    end
  end

  // Second cycle picks MUL or MULHU word
  assign result_o = high_q ? prod_q[2*XLEN-1:XLEN] : prod_q[XLEN-1:0];

  assign valid_o = s1_valid_q;
  // Busy in the cycle the operands are first presented
  assign ready_o = ready_i && (s1_valid_q || !valid_i);

endmodule

//--- logic/ex_op_pkg.sv
// Execute stage operation encodings and the mapping of each operation to its unit
package ex_op_pkg;

  // Operations accepted by the execute stage
  typedef enum logic [4:0] {
    // Arithmetic and logic
    ADD   = 5'd0,  SUB   = 5'd1,  AND  = 5'd2,  OR   = 5'd3,  XOR  = 5'd4,
    // Shifts
    SLL   = 5'd5,  SRL   = 5'd6,  SRA  = 5'd7,
    // Set on less than
    SLT   = 5'd8,  SLTU  = 5'd9,
    // Branch compares
    BEQ   = 5'd10, BNE   = 5'd11, BLT  = 5'd12, BGE  = 5'd13, BLTU = 5'd14, BGEU = 5'd15,
    // Multiplier, unsigned only
    MUL   = 5'd16, MULHU = 5'd17,
    // Divider, unsigned only
    DIVU  = 5'd18, REMU  = 5'd19
  } ex_op_e;

  // Unit that finishes an operation
  typedef enum logic [1:0] {
    UNIT_ALU    = 2'd0,
    UNIT_BRANCH = 2'd1,
    UNIT_MUL    = 2'd2,
    UNIT_DIV    = 2'd3
  } ex_unit_e;

  // Branches also run through the ALU comparator
  function automatic ex_unit_e op_unit(input ex_op_e op);
    case (op)
      BEQ, BNE, BLT, BGE, BLTU, BGEU: op_unit = UNIT_BRANCH;
      MUL, MULHU:                     op_unit = UNIT_MUL;
      DIVU, REMU:                     op_unit = UNIT_DIV;
      default:                        op_unit = UNIT_ALU;
    endcase
  endfunction

endpackage

//--- logic/ex_rf_pkg.sv
// Register file destination address width and type seen by the execute stage
package ex_rf_pkg;

  // 32 integer registers
  parameter int RF_ADDR_W = 5;

  // Destination register address
  typedef logic [RF_ADDR_W-1:0] rf_addr_t;

endpackage

//--- logic/ex_stage.sv
// Execute stage dispatching to ALU, multiplier and divider into the EX/WB register
`timescale 1ns/1ps

module ex_stage #(
  parameter int XLEN = 32
) (
  input  logic                  clk,
  input  logic                  rst_n,

  // From issue
  input  logic                  valid_i,
  input  ex_op_pkg::ex_op_e     op_i,
  input  logic [XLEN-1:0]       operand_a_i,
  input  logic [XLEN-1:0]       operand_b_i,
  input  logic [XLEN-1:0]       operand_c_i,
  input  ex_rf_pkg::rf_addr_t   rd_i,
  input  logic                  kill_i,
  output logic                  ready_o,

  // EX/WB register
  output logic                  wb_valid_o,
  output ex_rf_pkg::rf_addr_t   wb_rd_o,
  output logic [XLEN-1:0]       wb_data_o,
  input  logic                  wb_ready_i,

  // Branch outcome towards fetch
  output logic                  branch_decision_o,
  output logic [XLEN-1:0]       branch_target_o
);

  ex_op_pkg::ex_unit_e unit;

  logic            instr_valid;
  logic            alu_en_gated;
  logic            branch_en_gated;
  logic            mul_en_gated;
  logic            div_en_gated;

  logic [XLEN-1:0] alu_result;
  logic            alu_cmp_result;
  logic            alu_valid;
  logic            alu_ready;

  logic [XLEN-1:0] mul_result;
  logic            mul_valid;
  logic            mul_ready;

  logic [XLEN-1:0] div_result;
  logic            div_valid;
  logic            div_ready;

  logic [XLEN-1:0] ex_result;
  logic            ex_done;
  logic            rf_we;

  // Killed instruction looks like no instruction
  assign instr_valid = valid_i && !kill_i;
  assign unit        = ex_op_pkg::op_unit(op_i);

  // Per-unit enables, branches use the ALU comparator
  assign branch_en_gated = instr_valid && (unit == ex_op_pkg::UNIT_BRANCH);
  assign alu_en_gated    = instr_valid && ((unit == ex_op_pkg::UNIT_ALU) || branch_en_gated);
  assign mul_en_gated    = instr_valid && (unit == ex_op_pkg::UNIT_MUL);
  assign div_en_gated    = instr_valid && (unit == ex_op_pkg::UNIT_DIV);

  //////////////////////////////////////////////////
  // Units
  //////////////////////////////////////////////////

  ex_alu #(.XLEN(XLEN)) alu_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .op_i         (op_i),
    .operand_a_i  (operand_a_i),
    .operand_b_i  (operand_b_i),
    .result_o     (alu_result),
    .cmp_result_o (alu_cmp_result),
    .valid_i      (alu_en_gated),
    .valid_o      (alu_valid),
    .ready_o      (alu_ready),
    .ready_i      (wb_ready_i)
  );

  ex_mult #(.XLEN(XLEN)) mult_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .op_i         (op_i),
    .operand_a_i  (operand_a_i),
    .operand_b_i  (operand_b_i),
    .result_o     (mul_result),
    .valid_i      (mul_en_gated),
    .valid_o      (mul_valid),
    .ready_o      (mul_ready),
    .ready_i      (wb_ready_i)
  );

  ex_div #(.XLEN(XLEN)) div_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .op_i         (op_i),
    .operand_a_i  (operand_a_i),
    .operand_b_i  (operand_b_i),
    .result_o     (div_result),
    .valid_i      (div_en_gated),
    .kill_i       (kill_i),
    .valid_o      (div_valid),
    .ready_o      (div_ready),
    .ready_i      (wb_ready_i)
  );

  // Result of the unit that owns the operation
  always_comb
  begin
    case (unit)
      ex_op_pkg::UNIT_MUL: ex_result = mul_result;
      ex_op_pkg::UNIT_DIV: ex_result = div_result;
      default:             ex_result = alu_result;
    endcase
  end

  // Completion needs writeback to be free
  assign ex_done = ((alu_en_gated && alu_valid) ||
                    (mul_en_gated && mul_valid) ||
                    (div_en_gated && div_valid)) && wb_ready_i;

  // Branches finish here with nothing to write
  assign rf_we = ex_done && (unit != ex_op_pkg::UNIT_BRANCH);

  //////////////////////////////////////////////////
  // EX/WB register
  //////////////////////////////////////////////////

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
      wb_valid_o <= 1'b0;
    else if (ex_done)
      wb_valid_o <= rf_we;
    else if (wb_ready_i)
      // Nothing finished, insert a bubble
      wb_valid_o <= 1'b0;
  end

  // Stalled writeback keeps the previous values
  always_ff @(posedge clk)
  begin
    if (rf_we)
    begin
      wb_rd_o   <= rd_i;
      wb_data_o <= ex_result;
    end
  end

  // Kill frees issue at once
  assign ready_o = kill_i || (alu_ready && mul_ready && div_ready && wb_ready_i);

  // Branch outcome straight from the comparator
  assign branch_decision_o = branch_en_gated && alu_cmp_result;
  assign branch_target_o   = operand_c_i;

endmodule

//--- logic/ex_top.sv
// Execute subsystem top level fixing the datapath width
`timescale 1ns/1ps

module ex_top #(
  parameter int XLEN = 32
) (
  input  logic                  clk,
  input  logic                  rst_n,

  // Issue side
  input  logic                  valid_i,
  input  ex_op_pkg::ex_op_e     op_i,
  input  logic [XLEN-1:0]       operand_a_i,
  input  logic [XLEN-1:0]       operand_b_i,
  input  logic [XLEN-1:0]       operand_c_i,
  input  ex_rf_pkg::rf_addr_t   rd_i,
  input  logic                  kill_i,
  output logic                  ready_o,

  // Writeback side
  output logic                  wb_valid_o,
  output ex_rf_pkg::rf_addr_t   wb_rd_o,
  output logic [XLEN-1:0]       wb_data_o,
  input  logic                  wb_ready_i,

  // Branch outcome
  output logic                  branch_decision_o,
  output logic [XLEN-1:0]       branch_target_o
);

  ex_stage #(.XLEN(XLEN)) ex_stage_i (
    .clk               (clk),
    .rst_n             (rst_n),
    .valid_i           (valid_i),
    .op_i              (op_i),
    .operand_a_i       (operand_a_i),
    .operand_b_i       (operand_b_i),
    .operand_c_i       (operand_c_i),
    .rd_i              (rd_i),
    .kill_i            (kill_i),
    .ready_o           (ready_o),
    .wb_valid_o        (wb_valid_o),
    .wb_rd_o           (wb_rd_o),
    .wb_data_o         (wb_data_o),
    .wb_ready_i        (wb_ready_i),
    .branch_decision_o (branch_decision_o),
    .branch_target_o   (branch_target_o)
  );

endmodule

//--- sim/ex_clk_gen.sv
// Testbench clock and power-on reset source for the execute stage
`timescale 1ns/1ps

module ex_clk_gen #(
  parameter int PERIOD_NS  = 100,
  parameter int RST_CYCLES = 4
) (
  output logic clk_o,
  output logic rst_n_o
);

  // Free-running clock, starts low
  initial
  begin
    clk_o = 1'b0;
    forever
      #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // Reset low over the first rising edges
  // released right after an edge so no flop sees it change
  initial
  begin
    rst_n_o = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule

//--- sim/ex_tb.sv
// Testbench for the execute subsystem driven from a vector file with random writeback stalls
`timescale 1ns/1ps

module ex_tb;

  localparam int XLEN    = 32;
  // Cycles allowed for any single wait
  localparam int TIMEOUT = 200;

  logic                 clk;
  logic                 rst_n;

  // Issue side
  logic                 valid_i;
  ex_op_pkg::ex_op_e    op_i;
  logic [XLEN-1:0]      operand_a_i;
  logic [XLEN-1:0]      operand_b_i;
  logic [XLEN-1:0]      operand_c_i;
  ex_rf_pkg::rf_addr_t  rd_i;
  logic                 kill_i;
  logic                 ready_o;

  // Writeback side
  logic                 wb_valid_o;
  ex_rf_pkg::rf_addr_t  wb_rd_o;
  logic [XLEN-1:0]      wb_data_o;
  logic                 wb_ready_i;

  logic                 branch_decision_o;
  logic [XLEN-1:0]      branch_target_o;

  // Back-pressure control
  logic                 stall_en;
  int unsigned          seed;
  int unsigned          rnd;

  // Expected writebacks in issue order
  ex_rf_pkg::rf_addr_t  exp_rd_q[$];
  logic [XLEN-1:0]      exp_data_q[$];

  // Last writeback seen stalled, must not move
  logic                 hold_pend;
  ex_rf_pkg::rf_addr_t  hold_rd;
  logic [XLEN-1:0]      hold_data;
  ex_rf_pkg::rf_addr_t  mon_rd;
  logic [XLEN-1:0]      mon_data;

  // Vector file fields
  int                   fd;
  int                   n_chars;
  int                   n_fields;
  int                   n_instr;
  int                   wait_cycles;
  logic [8*160-1:0]     line;
  logic [63:0]          op_name;
  ex_op_pkg::ex_op_e    f_op;
  logic [XLEN-1:0]      f_a;
  logic [XLEN-1:0]      f_b;
  logic [XLEN-1:0]      f_c;
  logic [XLEN-1:0]      f_data;
  logic [31:0]          f_rd;
  logic [31:0]          f_br;
  logic [31:0]          f_kill;

  ex_clk_gen #(
    .PERIOD_NS  (100),
    .RST_CYCLES (4)
  ) clk_gen0 (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  ex_top #(.XLEN(XLEN)) dut0 (
    .clk               (clk),
    .rst_n             (rst_n),
    .valid_i           (valid_i),
    .op_i              (op_i),
    .operand_a_i       (operand_a_i),
    .operand_b_i       (operand_b_i),
    .operand_c_i       (operand_c_i),
    .rd_i              (rd_i),
    .kill_i            (kill_i),
    .ready_o           (ready_o),
    .wb_valid_o        (wb_valid_o),
    .wb_rd_o           (wb_rd_o),
    .wb_data_o         (wb_data_o),
    .wb_ready_i        (wb_ready_i),
    .branch_decision_o (branch_decision_o),
    .branch_target_o   (branch_target_o)
  );

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("Test FAILED");
    $fatal(1);
  endtask

  task automatic check(input logic [63:0] got, input logic [63:0] expected, input string what);
    if (got !== expected)
      stop_with_failure($sformatf("FAILED at %0t ns: %s, got %0h expected %0h",
                                  $time, what, got, expected));
  endtask

  // Operation names as written in the vector file
  task automatic decode_op(input logic [63:0] name, output ex_op_pkg::ex_op_e op);
    op = ex_op_pkg::ADD;
    case (name)
      "ADD":   op = ex_op_pkg::ADD;
      "SUB":   op = ex_op_pkg::SUB;
      "AND":   op = ex_op_pkg::AND;
      "OR":    op = ex_op_pkg::OR;
      "XOR":   op = ex_op_pkg::XOR;
      "SLL":   op = ex_op_pkg::SLL;
      "SRL":   op = ex_op_pkg::SRL;
      "SRA":   op = ex_op_pkg::SRA;
      "SLT":   op = ex_op_pkg::SLT;
      "SLTU":  op = ex_op_pkg::SLTU;
      "BEQ":   op = ex_op_pkg::BEQ;
      "BNE":   op = ex_op_pkg::BNE;
      "BLT":   op = ex_op_pkg::BLT;
      "BGE":   op = ex_op_pkg::BGE;
      "BLTU":  op = ex_op_pkg::BLTU;
      "BGEU":  op = ex_op_pkg::BGEU;
      "MUL":   op = ex_op_pkg::MUL;
      "MULHU": op = ex_op_pkg::MULHU;
      "DIVU":  op = ex_op_pkg::DIVU;
      "REMU":  op = ex_op_pkg::REMU;
      default: stop_with_failure($sformatf("Unknown operation %0s in the vector file", name));
    endcase
  endtask

  // Present one instruction and hold it until the edge that accepts it
  // Called at a rising edge, returns at the accepting edge
  task automatic run_instr(
    input ex_op_pkg::ex_op_e   op,
    input logic [XLEN-1:0]     a,
    input logic [XLEN-1:0]     b,
    input logic [XLEN-1:0]     c,
    input ex_rf_pkg::rf_addr_t rd,
    input logic [XLEN-1:0]     exp_data,
    input logic                exp_br,
    input logic                kill
  );
    ex_op_pkg::ex_unit_e unit;
    int                  cycles;
    logic                accepted;
    unit     = ex_op_pkg::op_unit(op);
    cycles   = 0;
    accepted = 1'b0;
    valid_i     <= 1'b1;
    op_i        <= op;
    operand_a_i <= a;
    operand_b_i <= b;
    operand_c_i <= c;
    rd_i        <= rd;
    // Divide is killed later, mid-run
    kill_i      <= kill && (unit != ex_op_pkg::UNIT_DIV);
    // Only live non-branch instructions write back
    if (!kill && unit != ex_op_pkg::UNIT_BRANCH)
    begin
      exp_rd_q.push_back(rd);
      exp_data_q.push_back(exp_data);
    end
    if (kill && unit == ex_op_pkg::UNIT_DIV)
    begin
      // Let the divider start iterating
      repeat (5)
      begin
        @(negedge clk);
        check(ready_o, 1'b0, "ready_o while divider runs");
      end
      @(posedge clk);
      kill_i <= 1'b1;
    end
    while (!accepted)
    begin
      @(negedge clk);
      if (unit == ex_op_pkg::UNIT_BRANCH && !kill)
      begin
        check(branch_decision_o, exp_br, "branch_decision_o");
        check(branch_target_o, c, "branch_target_o");
      end
      else
        check(branch_decision_o, 1'b0, "branch_decision_o on non-branch");
      if (ready_o)
        accepted = 1'b1;
      else
      begin
        cycles++;
        if (cycles > TIMEOUT)
          stop_with_failure("Timeout: the execute stage never accepted the instruction");
      end
    end
    // A divide starts from idle and runs every quotient bit, also after a kill
    if (unit == ex_op_pkg::UNIT_DIV && !kill)
      check(cycles >= XLEN + 1, 1'b1, "ready_o low for a full divide");
    @(posedge clk);
  endtask

  //////////////////////////////////////////////////
  // Writeback back-pressure and monitor
  //////////////////////////////////////////////////

  // Roughly one stalled cycle in four
  always @(posedge clk)
  begin
    if (stall_en)
    begin
      rnd = $urandom % 4;
      wb_ready_i <= (rnd != 0);
    end
    else
      wb_ready_i <= 1'b1;
  end

  // Mid-cycle sampling, inputs change only at rising edges
  always @(negedge clk)
  begin
    if (rst_n)
    begin
      if (hold_pend)
      begin
        check(wb_valid_o, 1'b1, "wb_valid_o held during stall");
        check(wb_rd_o, hold_rd, "wb_rd_o held during stall");
        check(wb_data_o, hold_data, "wb_data_o held during stall");
      end
      hold_pend = wb_valid_o && !wb_ready_i;
      hold_rd   = wb_rd_o;
      hold_data = wb_data_o;
      // Taken by writeback on the coming edge
      if (wb_valid_o && wb_ready_i)
      begin
        if (exp_rd_q.size() == 0)
          stop_with_failure("A writeback arrived with no result outstanding");
        else
        begin
          mon_rd   = exp_rd_q.pop_front();
          mon_data = exp_data_q.pop_front();
          check(wb_rd_o, mon_rd, "wb_rd_o order");
          check(wb_data_o, mon_data, $sformatf("wb_data_o for x%0d", mon_rd));
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial
  begin
    valid_i     = 1'b0;
    op_i        = ex_op_pkg::ADD;
    operand_a_i = '0;
    operand_b_i = '0;
    operand_c_i = '0;
    rd_i        = '0;
    kill_i      = 1'b0;
    wb_ready_i  = 1'b1;
    stall_en    = 1'b0;
    hold_pend   = 1'b0;
    n_instr     = 0;
    seed        = 25;
    rnd         = $urandom(seed);

    wait_cycles = 0;
    while (rst_n !== 1'b1)
    begin
      @(negedge clk);
      wait_cycles++;
      if (wait_cycles > TIMEOUT)
        stop_with_failure("Timeout: reset was never released");
    end

    // Idle after reset, divider free
    check(wb_valid_o, 1'b0, "wb_valid_o after reset");
    check(branch_decision_o, 1'b0, "branch_decision_o after reset");
    check(ready_o, 1'b1, "ready_o after reset");
    stall_en = 1'b1;
    @(posedge clk);

    fd = $fopen("sim/ex_tests.txt", "r");
    if (fd == 0)
      stop_with_failure("Could not open the vector file sim/ex_tests.txt");
    while (!$feof(fd))
    begin
      n_chars = $fgets(line, fd);
      if (n_chars > 0)
      begin
        // Comment and blank lines do not give all eight fields
        n_fields = $sscanf(line, "%s %h %h %h %h %h %h %h",
                           op_name, f_a, f_b, f_c, f_rd, f_data, f_br, f_kill);
        if (n_fields == 8)
        begin
          decode_op(op_name, f_op);
          run_instr(f_op, f_a, f_b, f_c, f_rd[ex_rf_pkg::RF_ADDR_W-1:0],
                    f_data, f_br[0], f_kill[0]);
          n_instr++;
        end
      end
    end
    $fclose(fd);
    valid_i <= 1'b0;
    kill_i  <= 1'b0;

    // Drain the EX/WB register
    wait_cycles = 0;
    while (exp_rd_q.size() != 0)
    begin
      @(negedge clk);
      wait_cycles++;
      if (wait_cycles > TIMEOUT)
        stop_with_failure("Timeout: no writeback arrived for the last results");
    end
    // Quiet period, anything more is a duplicate
    repeat (10) @(negedge clk);

    if (n_instr == 0)
      stop_with_failure("No test vectors were read from sim/ex_tests.txt");
    else
    begin
      $display("Test OK");
      $finish;
    end
  end

endmodule

//--- sim/ex_tests.txt
// Columns: op, operand a, operand b, operand c, rd, expected data, expected branch, kill
// Values are hex; branches expect no writeback, killed lines expect nothing
ADD   00000005 00000003 00000000 01 00000008 0 0
ADD   ffffffff 00000001 00000000 02 00000000 0 0
SUB   00000003 00000005 00000000 03 fffffffe 0 0
AND   f0f0ff00 0ff0f0f0 00000000 04 00f0f000 0 0
OR    f0f00000 0000000f 00000000 05 f0f0000f 0 0
XOR   aaaa5555 ffff0000 00000000 06 55555555 0 0
SLL   00000001 00000024 00000000 07 00000010 0 0
SRL   80000000 0000001f 00000000 08 00000001 0 0
SRA   80000000 00000004 00000000 09 f8000000 0 0
SLT   ffffffff 00000001 00000000 0a 00000001 0 0
SLTU  ffffffff 00000001 00000000 0b 00000000 0 0
BEQ   00001234 00001234 00000400 00 00000000 1 0
BNE   00001234 00001234 00000404 00 00000000 0 0
BLT   fffffff0 00000010 00000408 00 00000000 1 0
BGE   fffffff0 00000010 0000040c 00 00000000 0 0
BLTU  fffffff0 00000010 00000410 00 00000000 0 0
BGEU  fffffff0 00000010 00000414 00 00000000 1 0
MUL   0000ffff 0000ffff 00000000 0c fffe0001 0 0
MUL   ffffffff ffffffff 00000000 0d 00000001 0 0
MULHU ffffffff ffffffff 00000000 0e fffffffe 0 0
MULHU 00010000 00030000 00000000 0f 00000003 0 0
DIVU  00000064 00000007 00000000 10 0000000e 0 0
REMU  00000064 00000007 00000000 11 00000002 0 0
DIVU  12345678 00000000 00000000 12 ffffffff 0 0
REMU  12345678 00000000 00000000 13 12345678 0 0
ADD   00000001 00000001 00000000 14 00000002 0 1
DIVU  ffffffff 00000003 00000000 15 55555555 0 1
DIVU  ffffffff 00000003 00000000 16 55555555 0 0
REMU  ffffffff 00000010 00000000 17 0000000f 0 0
SUB   80000000 00000001 00000000 18 7fffffff 0 0
MUL   00000002 00000003 00000000 19 00000006 0 1
MUL   00000007 00000006 00000000 1a 0000002a 0 0

//--- sources.f
logic/ex_op_pkg.sv
logic/ex_rf_pkg.sv
logic/ex_alu.sv
logic/ex_mult.sv
logic/ex_div.sv
logic/ex_stage.sv
logic/ex_top.sv
sim/ex_clk_gen.sv
sim/ex_tb.sv
